/* bench/ctrlport_tb.sv */
/*
 * Control-port subsystem testbench
 * Directed tests over the scratch bank, the event counter, the address
 * windows and timed-request rejection, bounded by a cycle-count timeout
 */

`timescale 1ns/1ns
`default_nettype none

`include "ctrlport_cfg.svh"

module ctrlport_tb;

  import ctrlport_pkg::*;

  localparam int CLK_HALF       = 20;
  localparam int ACK_LIMIT      = 3;
  localparam int UNMAPPED_LIMIT = 6;
  // The directed tests need about 600 cycles and the limit leaves generous margin
  localparam int TEST_CYCLES    = 600;
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 200;
  localparam logic [31:0] LFSR_SEED = 32'd88393;
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;
  localparam ctrlport_time_t TIMED_STAMP = 64'd1000;

  // The counter window follows the scratch window directly
  localparam ctrlport_addr_t SCRATCH_BASE = `CTRLPORT_BASE_ADDR;
  localparam ctrlport_addr_t COUNTER_BASE =
    `CTRLPORT_BASE_ADDR + (20'd1 << `CTRLPORT_SLAVE_ADDR_W);

  logic              ctrlport_clk = 1'b0;
  logic              ctrlport_rst;
  logic              s_req_wr;
  logic              s_req_rd;
  ctrlport_addr_t    s_req_addr;
  ctrlport_data_t    s_req_data;
  ctrlport_byte_en_t s_req_byte_en;
  logic              s_req_has_time;
  ctrlport_time_t    s_req_time;
  logic              s_resp_ack;
  ctrlport_status_t  s_resp_status;
  ctrlport_data_t    s_resp_data;
  logic              event_pulse;
  logic              threshold_hit;

  int          cycle_count = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_error_base = 0;
  logic [31:0] lfsr_state = LFSR_SEED;

  // Expected scratch contents as the tests have written them
  ctrlport_data_t scratch_model [4];

  ctrlport_subsystem uut (
    .ctrlport_clk   (ctrlport_clk),
    .ctrlport_rst   (ctrlport_rst),
    .s_req_wr       (s_req_wr),
    .s_req_rd       (s_req_rd),
    .s_req_addr     (s_req_addr),
    .s_req_data     (s_req_data),
    .s_req_byte_en  (s_req_byte_en),
    .s_req_has_time (s_req_has_time),
    .s_req_time     (s_req_time),
    .s_resp_status  (s_resp_status),
    .s_resp_ack     (s_resp_ack),
    .s_resp_data    (s_resp_data),
    .event_pulse    (event_pulse),
    .threshold_hit  (threshold_hit)
  );

  always #(CLK_HALF) ctrlport_clk = ~ctrlport_clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Right-shifting Galois LFSR that yields one bit per call
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out_bit;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  // Enabled lanes take the new byte and the others keep the old one
  function automatic ctrlport_data_t merge_bytes(input ctrlport_data_t old_word,
                                                 input ctrlport_data_t new_word,
                                                 input ctrlport_byte_en_t byte_en);
    ctrlport_data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (byte_en[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic begin_test();
    test_error_base = errors;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_error_base) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_error_base);
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus access
  // ----------------------------------------------------------------------

  // Latency counts clock edges from the strobe edge to the ack
  task automatic bus_access(input logic is_write, input ctrlport_addr_t addr,
                            input ctrlport_data_t wdata, input ctrlport_byte_en_t byte_en,
                            input logic has_time, input int limit, output logic got_ack,
                            output ctrlport_status_t status, output ctrlport_data_t rdata,
                            output int latency);
    got_ack = 1'b0;
    status  = STS_OKAY;
    rdata   = '0;
    latency = 1;
    @(posedge ctrlport_clk);
    s_req_wr       <= is_write;
    s_req_rd       <= !is_write;
    s_req_addr     <= addr;
    s_req_data     <= wdata;
    s_req_byte_en  <= byte_en;
    s_req_has_time <= has_time;
    s_req_time     <= has_time ? TIMED_STAMP : '0;
    @(posedge ctrlport_clk);
    s_req_wr       <= 1'b0;
    s_req_rd       <= 1'b0;
    s_req_has_time <= 1'b0;
    // Response is sampled mid-cycle where it is stable
    while (!got_ack && latency <= limit) begin
      @(negedge ctrlport_clk);
      if (s_resp_ack) begin
        got_ack = 1'b1;
        status  = s_resp_status;
        rdata   = s_resp_data;
      end else begin
        @(posedge ctrlport_clk);
        latency++;
      end
    end
  endtask

  task automatic bus_write(input ctrlport_addr_t addr, input ctrlport_data_t data,
                           input ctrlport_byte_en_t byte_en, input logic has_time,
                           output ctrlport_status_t status, output int latency);
    logic           got_ack;
    ctrlport_data_t rdata;
    bus_access(1'b1, addr, data, byte_en, has_time, ACK_LIMIT, got_ack, status, rdata,
               latency);
    if (!got_ack) begin
      errors++;
      $display("ERROR at %0t ns: write to %h got no ack within %0d cycles",
               $time, addr, ACK_LIMIT);
    end
  endtask

  task automatic bus_read(input ctrlport_addr_t addr, output ctrlport_status_t status,
                          output ctrlport_data_t data, output int latency);
    logic got_ack;
    bus_access(1'b0, addr, '0, 4'hF, 1'b0, ACK_LIMIT, got_ack, status, data, latency);
    if (!got_ack) begin
      errors++;
      $display("ERROR at %0t ns: read from %h got no ack within %0d cycles",
               $time, addr, ACK_LIMIT);
    end
  endtask

  // An address outside both windows must stay silent
  task automatic probe_unmapped(input ctrlport_addr_t addr, input logic is_write);
    logic             got_ack;
    ctrlport_status_t status;
    ctrlport_data_t   rdata;
    int               latency;
    bus_access(is_write, addr, random_bits(32), 4'hF, 1'b0, UNMAPPED_LIMIT, got_ack,
               status, rdata, latency);
    if (got_ack) begin
      errors++;
      $display("ERROR at %0t ns: unmapped address %h was acknowledged", $time, addr);
    end
  endtask

  // Holds event_pulse high for the given number of consecutive cycles
  task automatic pulse_events(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge ctrlport_clk);
      event_pulse <= 1'b1;
    end
    @(posedge ctrlport_clk);
    event_pulse <= 1'b0;
  endtask

  // The flag follows the count one cycle later
  task automatic wait_flag_update();
    @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------

  task automatic test_scratch_readback();
    ctrlport_status_t status;
    ctrlport_data_t   rdata;
    int               latency;
    begin_test();
    for (int i = 0; i < 4; i++) begin
      scratch_model[i] = random_bits(32);
      bus_write(SCRATCH_BASE + ctrlport_addr_t'(i), scratch_model[i], 4'hF, 1'b0,
                status, latency);
      check_value("s_resp_status", status, STS_OKAY);
      check_value("write ack latency", latency, 3);
    end
    for (int i = 0; i < 4; i++) begin
      bus_read(SCRATCH_BASE + ctrlport_addr_t'(i), status, rdata, latency);
      check_value("s_resp_status", status, STS_OKAY);
      check_value("s_resp_data", rdata, scratch_model[i]);
      check_value("read ack latency", latency, 3);
    end
    report_test("scratch readback");
  endtask

  task automatic test_byte_enables();
    ctrlport_status_t status;
    ctrlport_data_t   rdata;
    ctrlport_data_t   old_word;
    ctrlport_data_t   new_word;
    int               latency;
    begin_test();
    old_word = random_bits(32);
    new_word = random_bits(32);
    bus_write(SCRATCH_BASE + 20'd2, old_word, 4'hF, 1'b0, status, latency);
    bus_write(SCRATCH_BASE + 20'd2, new_word, 4'b0101, 1'b0, status, latency);
    scratch_model[2] = merge_bytes(old_word, new_word, 4'b0101);
    bus_read(SCRATCH_BASE + 20'd2, status, rdata, latency);
    check_value("s_resp_status", status, STS_OKAY);
    check_value("scratch merged data", rdata, scratch_model[2]);
    // Same rule on the threshold register, using the other lanes
    old_word = random_bits(32);
    new_word = random_bits(32);
    bus_write(COUNTER_BASE + 20'd1, old_word, 4'hF, 1'b0, status, latency);
    bus_write(COUNTER_BASE + 20'd1, new_word, 4'b1010, 1'b0, status, latency);
    bus_read(COUNTER_BASE + 20'd1, status, rdata, latency);
    check_value("s_resp_status", status, STS_OKAY);
    check_value("threshold merged data", rdata, merge_bytes(old_word, new_word, 4'b1010));
    bus_write(COUNTER_BASE + 20'd1, '0, 4'hF, 1'b0, status, latency);
    report_test("byte enables");
  endtask

  task automatic test_decode_windows();
    ctrlport_status_t status;
    ctrlport_data_t   rdata;
    int               latency;
    begin_test();
    probe_unmapped(20'h00000, 1'b1);
    probe_unmapped(20'h00300, 1'b0);
    probe_unmapped(20'h00600, 1'b0);
    bus_read(SCRATCH_BASE + 20'd4, status, rdata, latency);
    check_value("s_resp_status", status, STS_CMDERR);
    check_value("s_resp_data", rdata, 32'h0);
    bus_read(COUNTER_BASE + 20'd5, status, rdata, latency);
    check_value("s_resp_status", status, STS_CMDERR);
    report_test("decode windows");
  endtask

  task automatic test_timed_requests();
    ctrlport_status_t status;
    ctrlport_data_t   rdata;
    int               latency;
    begin_test();
    bus_write(SCRATCH_BASE + 20'd1, random_bits(32), 4'hF, 1'b1, status, latency);
    check_value("s_resp_status", status, STS_TSERR);
    bus_read(SCRATCH_BASE + 20'd1, status, rdata, latency);
    check_value("s_resp_status", status, STS_OKAY);
    check_value("scratch after timed write", rdata, scratch_model[1]);
    bus_write(COUNTER_BASE + 20'd1, random_bits(32), 4'hF, 1'b1, status, latency);
    check_value("s_resp_status", status, STS_TSERR);
    bus_read(COUNTER_BASE + 20'd1, status, rdata, latency);
    check_value("threshold after timed write", rdata, 32'h0);
    report_test("timed requests");
  endtask

  task automatic test_counter();
    ctrlport_status_t status;
    ctrlport_data_t   rdata;
    int               latency;
    int               pulses;
    begin_test();
    bus_write(COUNTER_BASE, random_bits(32), 4'hF, 1'b0, status, latency);
    check_value("s_resp_status", status, STS_OKAY);
    pulses = int'(random_bits(5)) + 1;
    pulse_events(pulses);
    bus_read(COUNTER_BASE, status, rdata, latency);
    check_value("s_resp_status", status, STS_OKAY);
    check_value("event count", rdata, pulses);
    report_test("counter");
  endtask

  task automatic test_threshold_flag();
    ctrlport_status_t status;
    ctrlport_data_t   count;
    int               latency;
    begin_test();
    bus_read(COUNTER_BASE, status, count, latency);
    // The threshold is still zero while the count is not, so the flag stays off
    check_value("threshold_hit", threshold_hit, 1'b0);
    bus_write(COUNTER_BASE + 20'd1, count + 32'd2, 4'hF, 1'b0, status, latency);
    check_value("threshold_hit", threshold_hit, 1'b0);
    pulse_events(1);
    wait_flag_update();
    check_value("threshold_hit", threshold_hit, 1'b0);
    pulse_events(1);
    wait_flag_update();
    check_value("threshold_hit", threshold_hit, 1'b1);
    bus_write(COUNTER_BASE, '0, 4'hF, 1'b0, status, latency);
    check_value("threshold_hit", threshold_hit, 1'b0);
    report_test("threshold flag");
  endtask

  // ----------------------------------------------------------------------
  // Sequence and timeout
  // ----------------------------------------------------------------------

  always @(posedge ctrlport_clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("ERROR: simulation stopped by timeout after %0d cycles", cycle_count);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    ctrlport_rst   <= 1'b1;
    s_req_wr       <= 1'b0;
    s_req_rd       <= 1'b0;
    s_req_addr     <= '0;
    s_req_data     <= '0;
    s_req_byte_en  <= '0;
    s_req_has_time <= 1'b0;
    s_req_time     <= '0;
    event_pulse    <= 1'b0;
    repeat (2) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;
    test_scratch_readback();
    test_byte_enables();
    test_decode_windows();
    test_timed_requests();
    test_counter();
    test_threshold_flag();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : ctrlport_tb

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/ctrlport_pkg.sv
rtl/ctrlport_decoder.sv
rtl/ctrlport_scratch_regs.sv
rtl/ctrlport_event_counter.sv
rtl/ctrlport_subsystem.sv
bench/ctrlport_tb.sv

/* rtl/ctrlport_cfg.svh */
/*
 * Control-port subsystem configuration
 * Endpoint count and address map of the register subsystem
 */

`ifndef CTRLPORT_CFG_SVH
`define CTRLPORT_CFG_SVH

// Number of endpoints hanging off the decoder
`define CTRLPORT_NUM_PORTS 2

// First address of endpoint 0, the windows follow back to back
`define CTRLPORT_BASE_ADDR 20'h00400

// Address bits handed to each endpoint, so each window is 256 words
`define CTRLPORT_SLAVE_ADDR_W 8

// With these values the map becomes
//   0x400 to 0x4FF  scratch register bank
//   0x500 to 0x5FF  event counter

`endif

/* rtl/ctrlport_decoder.sv */
/*
 * Control-port address decoder
 * Steers one master request to the endpoint whose window holds the address
 * and merges the endpoint responses into one registered response
 */

`timescale 1ns/1ns
`default_nettype none

module ctrlport_decoder #(
  parameter int                          NUM_SLAVES   = 2,
  parameter ctrlport_pkg::ctrlport_addr_t BASE_ADDR    = 20'h00000,
  parameter int                          SLAVE_ADDR_W = 8
) (
  input  wire                                  ctrlport_clk,
  input  wire                                  ctrlport_rst,

  // Master side
  input  wire                                  s_ctrlport_req_wr,
  input  wire                                  s_ctrlport_req_rd,
  input  wire ctrlport_pkg::ctrlport_addr_t    s_ctrlport_req_addr,
  input  wire ctrlport_pkg::ctrlport_data_t    s_ctrlport_req_data,
  input  wire ctrlport_pkg::ctrlport_byte_en_t s_ctrlport_req_byte_en,
  input  wire                                  s_ctrlport_req_has_time,
  input  wire ctrlport_pkg::ctrlport_time_t    s_ctrlport_req_time,
  output logic                                 s_ctrlport_resp_ack,
  output ctrlport_pkg::ctrlport_status_t       s_ctrlport_resp_status,
  output ctrlport_pkg::ctrlport_data_t         s_ctrlport_resp_data,

  // Endpoint side, one slice per endpoint
  output logic [NUM_SLAVES-1:0] m_ctrlport_req_wr,
  output logic [NUM_SLAVES-1:0] m_ctrlport_req_rd,
  output logic [NUM_SLAVES*$bits(ctrlport_pkg::ctrlport_addr_t)-1:0]    m_ctrlport_req_addr,
  output logic [NUM_SLAVES*$bits(ctrlport_pkg::ctrlport_data_t)-1:0]    m_ctrlport_req_data,
  output logic [NUM_SLAVES*$bits(ctrlport_pkg::ctrlport_byte_en_t)-1:0] m_ctrlport_req_byte_en,
  output logic [NUM_SLAVES-1:0] m_ctrlport_req_has_time,
  output logic [NUM_SLAVES*$bits(ctrlport_pkg::ctrlport_time_t)-1:0]    m_ctrlport_req_time,
  input  wire  [NUM_SLAVES-1:0] m_ctrlport_resp_ack,
  input  wire  [NUM_SLAVES*$bits(ctrlport_pkg::ctrlport_status_t)-1:0]  m_ctrlport_resp_status,
  input  wire  [NUM_SLAVES*$bits(ctrlport_pkg::ctrlport_data_t)-1:0]    m_ctrlport_resp_data
);

  import ctrlport_pkg::*;

  localparam int ADDR_W  = $bits(ctrlport_addr_t);
  localparam int DATA_W  = $bits(ctrlport_data_t);
  localparam int BE_W    = $bits(ctrlport_byte_en_t);
  localparam int TIME_W  = $bits(ctrlport_time_t);
  localparam int STS_W   = $bits(ctrlport_status_t);

  // Address layout is | base | port number | endpoint offset |
  localparam int PORT_NUM_W    = $clog2(NUM_SLAVES);
  localparam int BASE_ADDR_POS = SLAVE_ADDR_W + PORT_NUM_W;

  localparam ctrlport_addr_t BASE_ADDR_MASK  = {ADDR_W{1'b1}} << BASE_ADDR_POS;
  localparam ctrlport_addr_t SLAVE_ADDR_MASK = ~({ADDR_W{1'b1}} << SLAVE_ADDR_W);

  // ----------------------------------------------------------------------
  // Request split
  // ----------------------------------------------------------------------

  logic                  base_hit;
  ctrlport_addr_t        port_num;
  logic [NUM_SLAVES-1:0] slave_hit;

  // With a single endpoint the base mask covers every upper bit, so the
  // port number comes out as zero and the compare below still works
  assign base_hit = ((s_ctrlport_req_addr & BASE_ADDR_MASK) == BASE_ADDR);
  assign port_num = (s_ctrlport_req_addr & ~BASE_ADDR_MASK) >> SLAVE_ADDR_W;

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      slave_hit[i] = base_hit && (port_num == ctrlport_addr_t'(i));
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      m_ctrlport_req_wr <= '0;
      m_ctrlport_req_rd <= '0;
    end else begin
      // Only the addressed endpoint sees a strobe, unmapped requests are dropped
      m_ctrlport_req_wr <= {NUM_SLAVES{s_ctrlport_req_wr}} & slave_hit;
      m_ctrlport_req_rd <= {NUM_SLAVES{s_ctrlport_req_rd}} & slave_hit;
    end

    // Payload goes to every endpoint and only matters next to a strobe
    for (int i = 0; i < NUM_SLAVES; i++) begin
      m_ctrlport_req_addr[ADDR_W*i +: ADDR_W]  <= s_ctrlport_req_addr & SLAVE_ADDR_MASK;
      m_ctrlport_req_data[DATA_W*i +: DATA_W]  <= s_ctrlport_req_data;
      m_ctrlport_req_byte_en[BE_W*i +: BE_W]   <= s_ctrlport_req_byte_en;
      m_ctrlport_req_has_time[i]               <= s_ctrlport_req_has_time;
      m_ctrlport_req_time[TIME_W*i +: TIME_W]  <= s_ctrlport_req_time;
    end
  end

  // ----------------------------------------------------------------------
  // Response merge
  // ----------------------------------------------------------------------

  logic             any_ack;
  logic [STS_W-1:0] status_or;
  ctrlport_data_t   data_or;

  // Each response is masked by its own ack, so idle endpoints add nothing
  always_comb begin
    any_ack   = 1'b0;
    status_or = '0;
    data_or   = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      any_ack   = any_ack | m_ctrlport_resp_ack[s];
      status_or = status_or |
                  (m_ctrlport_resp_status[STS_W*s +: STS_W] & {STS_W{m_ctrlport_resp_ack[s]}});
      data_or   = data_or |
                  (m_ctrlport_resp_data[DATA_W*s +: DATA_W] & {DATA_W{m_ctrlport_resp_ack[s]}});
    end
  end

  // Registered merge keeps the endpoint logic off the master's timing path
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      s_ctrlport_resp_ack <= 1'b0;
    end else begin
      s_ctrlport_resp_ack <= any_ack;
    end
    s_ctrlport_resp_status <= ctrlport_status_t'(status_or);
    s_ctrlport_resp_data   <= data_or;
  end

endmodule : ctrlport_decoder

`default_nettype wire

/* rtl/ctrlport_event_counter.sv */
/*
 * Event counter with threshold
 * Counts event pulses, compares the count against a programmable
 * threshold and raises a registered flag once it is reached
 */

`timescale 1ns/1ns
`default_nettype none

module ctrlport_event_counter (
  input  wire                                  ctrlport_clk,
  input  wire                                  ctrlport_rst,
  input  wire                                  req_wr,
  input  wire                                  req_rd,
  input  wire ctrlport_pkg::ctrlport_addr_t    req_addr,
  input  wire ctrlport_pkg::ctrlport_data_t    req_data,
  input  wire ctrlport_pkg::ctrlport_byte_en_t req_byte_en,
  input  wire                                  req_has_time,
  input  wire                                  event_pulse,
  output logic                                 resp_ack,
  output ctrlport_pkg::ctrlport_status_t       resp_status,
  output ctrlport_pkg::ctrlport_data_t         resp_data,
  output logic                                 threshold_hit
);

  import ctrlport_pkg::*;

  // Register offsets in the endpoint window
  localparam ctrlport_addr_t REG_COUNT     = 20'd0;
  localparam ctrlport_addr_t REG_THRESHOLD = 20'd1;
  localparam int             NUM_BYTES     = $bits(ctrlport_byte_en_t);

  ctrlport_data_t   count;
  ctrlport_data_t   threshold;
  logic             sel_count;
  logic             sel_threshold;
  logic             wr_ok;
  ctrlport_status_t next_status;
  ctrlport_data_t   next_data;

  assign sel_count     = (req_addr == REG_COUNT);
  assign sel_threshold = (req_addr == REG_THRESHOLD);
  assign wr_ok         = req_wr && !req_has_time;

  always_comb begin
    next_status = STS_OKAY;
    next_data   = '0;
    if (req_has_time) begin
      next_status = STS_TSERR;
    end else if (!(sel_count || sel_threshold)) begin
      next_status = STS_CMDERR;
    end else if (req_rd) begin
      next_data = sel_count ? count : threshold;
    end
  end

  // ----------------------------------------------------------------------
  // Count, threshold and flag
  // ----------------------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack      <= 1'b0;
      count         <= '0;
      threshold     <= '0;
      threshold_hit <= 1'b0;
    end else begin
      resp_ack <= req_wr | req_rd;

      // A write of any value clears the count, and the clear beats a pulse
      if (wr_ok && sel_count) begin
        count <= '0;
      end else if (event_pulse) begin
        count <= count + 1'b1;
      end

      if (wr_ok && sel_threshold) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (req_byte_en[b]) begin
            threshold[8*b +: 8] <= req_data[8*b +: 8];
          end
        end
      end

      // A zero threshold keeps the flag off
      threshold_hit <= (threshold != '0) && (count >= threshold);
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    resp_status <= next_status;
    resp_data   <= next_data;
  end

endmodule : ctrlport_event_counter

`default_nettype wire

/* rtl/ctrlport_pkg.sv */
/*
 * Control-port shared types
 * Field types for the request and response sides of the control port,
 * plus the response status codes used by every endpoint
 */

`default_nettype none

package ctrlport_pkg;

  // ----------------------------------------------------------------------
  // Request fields
  // ----------------------------------------------------------------------

  // Word address as seen by the master, endpoints see a stripped copy
  typedef logic [19:0] ctrlport_addr_t;

  // Write data on requests and read data on responses
  typedef logic [31:0] ctrlport_data_t;

  // One enable per byte lane of the data word
  typedef logic [3:0]  ctrlport_byte_en_t;

  // Timestamp for timed commands
  typedef logic [63:0] ctrlport_time_t;

  // ----------------------------------------------------------------------
  // Response status
  // ----------------------------------------------------------------------

  // STS_WARNING exists in the encoding but no endpoint here returns it
  typedef enum logic [1:0] {
    STS_OKAY    = 2'd0,
    STS_CMDERR  = 2'd1,
    STS_TSERR   = 2'd2,
    STS_WARNING = 2'd3
  } ctrlport_status_t;

endpackage : ctrlport_pkg

`default_nettype wire

/* rtl/ctrlport_scratch_regs.sv */
/*
 * Scratch register bank
 * Four 32-bit read-write registers with byte-lane writes
 */

`timescale 1ns/1ns
`default_nettype none

module ctrlport_scratch_regs (
  input  wire                                  ctrlport_clk,
  input  wire                                  ctrlport_rst,
  input  wire                                  req_wr,
  input  wire                                  req_rd,
  input  wire ctrlport_pkg::ctrlport_addr_t    req_addr,
  input  wire ctrlport_pkg::ctrlport_data_t    req_data,
  input  wire ctrlport_pkg::ctrlport_byte_en_t req_byte_en,
  input  wire                                  req_has_time,
  output logic                                 resp_ack,
  output ctrlport_pkg::ctrlport_status_t       resp_status,
  output ctrlport_pkg::ctrlport_data_t         resp_data
);

  import ctrlport_pkg::*;

  localparam int NUM_REGS = 4;
  localparam int NUM_BYTES = $bits(ctrlport_byte_en_t);

  ctrlport_data_t   regs [NUM_REGS];
  logic             addr_ok;
  logic [1:0]       reg_idx;
  logic             write_ok;
  ctrlport_status_t next_status;
  ctrlport_data_t   next_data;

  assign addr_ok  = (req_addr < ctrlport_addr_t'(NUM_REGS));
  assign reg_idx  = req_addr[1:0];
  // Timed commands are refused, so they never touch the bank
  assign write_ok = req_wr && !req_has_time && addr_ok;

  // Timestamp error wins over a bad offset
  always_comb begin
    next_status = STS_OKAY;
    next_data   = '0;
    if (req_has_time) begin
      next_status = STS_TSERR;
    end else if (!addr_ok) begin
      next_status = STS_CMDERR;
    end else if (req_rd) begin
      next_data = regs[reg_idx];
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Every strobe is answered on the next cycle
      resp_ack <= req_wr | req_rd;
      if (write_ok) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (req_byte_en[b]) begin
            regs[reg_idx][8*b +: 8] <= req_data[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    resp_status <= next_status;
    resp_data   <= next_data;
  end

endmodule : ctrlport_scratch_regs

`default_nettype wire

/* rtl/ctrlport_subsystem.sv */
/*
 * Control-port register subsystem
 * One master port decoded onto a scratch register bank and an event counter
 */

`timescale 1ns/1ns
`default_nettype none

`include "ctrlport_cfg.svh"

module ctrlport_subsystem (
  input  wire                                  ctrlport_clk,
  input  wire                                  ctrlport_rst,
  input  wire                                  s_req_wr,
  input  wire                                  s_req_rd,
  input  wire ctrlport_pkg::ctrlport_addr_t    s_req_addr,
  input  wire ctrlport_pkg::ctrlport_data_t    s_req_data,
  input  wire ctrlport_pkg::ctrlport_byte_en_t s_req_byte_en,
  input  wire                                  s_req_has_time,
  input  wire ctrlport_pkg::ctrlport_time_t    s_req_time,
  output ctrlport_pkg::ctrlport_status_t       s_resp_status,
  output logic                                 s_resp_ack,
  output ctrlport_pkg::ctrlport_data_t         s_resp_data,
  input  wire                                  event_pulse,
  output logic                                 threshold_hit
);

  import ctrlport_pkg::*;

  localparam int NP     = `CTRLPORT_NUM_PORTS;
  localparam int ADDR_W = $bits(ctrlport_addr_t);
  localparam int DATA_W = $bits(ctrlport_data_t);
  localparam int BE_W   = $bits(ctrlport_byte_en_t);
  localparam int STS_W  = $bits(ctrlport_status_t);

  // Flattened endpoint buses, slice 0 is the scratch bank, slice 1 the counter
  logic [NP-1:0]        ep_req_wr;
  logic [NP-1:0]        ep_req_rd;
  logic [NP*ADDR_W-1:0] ep_req_addr;
  logic [NP*DATA_W-1:0] ep_req_data;
  logic [NP*BE_W-1:0]   ep_req_byte_en;
  logic [NP-1:0]        ep_req_has_time;
  logic [NP-1:0]        ep_resp_ack;
  logic [NP*STS_W-1:0]  ep_resp_status;
  logic [NP*DATA_W-1:0] ep_resp_data;

  // The timestamp output stays open because neither endpoint runs timed commands
  ctrlport_decoder #(
    .NUM_SLAVES   (`CTRLPORT_NUM_PORTS),
    .BASE_ADDR    (`CTRLPORT_BASE_ADDR),
    .SLAVE_ADDR_W (`CTRLPORT_SLAVE_ADDR_W)
  ) u_decoder (
    .ctrlport_clk            (ctrlport_clk),
    .ctrlport_rst            (ctrlport_rst),
    .s_ctrlport_req_wr       (s_req_wr),
    .s_ctrlport_req_rd       (s_req_rd),
    .s_ctrlport_req_addr     (s_req_addr),
    .s_ctrlport_req_data     (s_req_data),
    .s_ctrlport_req_byte_en  (s_req_byte_en),
    .s_ctrlport_req_has_time (s_req_has_time),
    .s_ctrlport_req_time     (s_req_time),
    .s_ctrlport_resp_ack     (s_resp_ack),
    .s_ctrlport_resp_status  (s_resp_status),
    .s_ctrlport_resp_data    (s_resp_data),
    .m_ctrlport_req_wr       (ep_req_wr),
    .m_ctrlport_req_rd       (ep_req_rd),
    .m_ctrlport_req_addr     (ep_req_addr),
    .m_ctrlport_req_data     (ep_req_data),
    .m_ctrlport_req_byte_en  (ep_req_byte_en),
    .m_ctrlport_req_has_time (ep_req_has_time),
    .m_ctrlport_req_time     (),
    .m_ctrlport_resp_ack     (ep_resp_ack),
    .m_ctrlport_resp_status  (ep_resp_status),
    .m_ctrlport_resp_data    (ep_resp_data)
  );

  ctrlport_scratch_regs u_scratch (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (ep_req_wr[0]),
    .req_rd       (ep_req_rd[0]),
    .req_addr     (ep_req_addr[0*ADDR_W +: ADDR_W]),
    .req_data     (ep_req_data[0*DATA_W +: DATA_W]),
    .req_byte_en  (ep_req_byte_en[0*BE_W +: BE_W]),
    .req_has_time (ep_req_has_time[0]),
    .resp_ack     (ep_resp_ack[0]),
    .resp_status  (ep_resp_status[0*STS_W +: STS_W]),
    .resp_data    (ep_resp_data[0*DATA_W +: DATA_W])
  );

  ctrlport_event_counter u_counter (
    .ctrlport_clk  (ctrlport_clk),
    .ctrlport_rst  (ctrlport_rst),
    .req_wr        (ep_req_wr[1]),
    .req_rd        (ep_req_rd[1]),
    .req_addr      (ep_req_addr[1*ADDR_W +: ADDR_W]),
    .req_data      (ep_req_data[1*DATA_W +: DATA_W]),
    .req_byte_en   (ep_req_byte_en[1*BE_W +: BE_W]),
    .req_has_time  (ep_req_has_time[1]),
    .event_pulse   (event_pulse),
    .resp_ack      (ep_resp_ack[1]),
    .resp_status   (ep_resp_status[1*STS_W +: STS_W]),
    .resp_data     (ep_resp_data[1*DATA_W +: DATA_W]),
    .threshold_hit (threshold_hit)
  );

endmodule : ctrlport_subsystem

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the control-port subsystem testbench with Verilator and run it.
# The exit status is nonzero unless the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ctrlport_tb -f project.f -o ctrlport_sim \
  && ./obj_dir/ctrlport_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
